// ==== include/cfg_bridge_defines.svh ====
//--------------------------------------
// Widths and addresses follow the hard IP
// configuration tap; port 0 stays enabled
//--------------------------------------
`ifndef CFG_BRIDGE_DEFINES_SVH
`define CFG_BRIDGE_DEFINES_SVH

// Configuration tap widths
`define CFG_ADDR_W 4
`define CFG_DATA_W 32
`define BUSDEV_W 13
`define MSI_ADDR_W 64

// Rx master read-return ports
`define RXM_PORTS 6
`define RXM_DATA_W 64
`define RXM_PORT_ENA 6'b010101   // One bit per BAR, port 0 always set

// Configuration tap register addresses
`define CFG_ADR_DEVCSR 4'h0
`define CFG_ADR_PRMCSR 4'h3
`define CFG_ADR_MSIADR_L0 4'h5   // MSI address [11:0]
`define CFG_ADR_MSIADR_H0 4'h6   // MSI address [43:32]
`define CFG_ADR_MSIADR_L1 4'h9   // MSI address [31:12]
`define CFG_ADR_MSIADR_H1 4'hB   // MSI address [63:44]
`define CFG_ADR_MSICTL 4'hD
`define CFG_ADR_BUSDEV 4'hF

`endif

// ==== design/cfg_bridge_pkg.sv ====
//--------------------------------------
// Types only; widths come from the defines
//--------------------------------------
`include "cfg_bridge_defines.svh"

package cfg_bridge_pkg;

   typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;
   typedef logic [`CFG_DATA_W-1:0] cfg_data_t;
   typedef logic [`BUSDEV_W-1:0] busdev_t;
   typedef logic [`MSI_ADDR_W-1:0] msi_addr_t;
   typedef logic [15:0] half_t;   // MSI/MSI-X control, MSI data, command

   typedef logic [`RXM_DATA_W-1:0] rxm_data_t;
   typedef logic [`RXM_PORTS-1:0] rxm_vec_t;

   // MSI status word, 82 bits, MSB first
   typedef struct packed
   {
      logic master_ena;   // Bit 81
      logic msi_ena;      // Bit 80
      half_t msi_data;    // Bits 79:64
      msi_addr_t msi_addr;
   } msi_intfc_t;

endpackage

// ==== design/reset_sync.sv ====
//--------------------------------------
// Asserts at once, releases on 2nd edge
//--------------------------------------
`timescale 1ns/1ps

module reset_sync
(
   input  logic AvlClk_i,
   input  logic rst_n_i,
   output logic rstn_o
);

   logic rstn_r;
   logic rstn_rr;

   // Shift a one through two flops once the input reset is gone
   always_ff @(posedge AvlClk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rstn_r  <= 1'b0;
         rstn_rr <= 1'b0;
      end
      else
      begin
         rstn_r  <= 1'b1;
         rstn_rr <= rstn_r;
      end
   end

   assign rstn_o = rstn_rr;

   // Release needs the input high across the whole release window
   a_clean_release: assert property (@(posedge AvlClk_i)
      $rose(rstn_o) |-> rst_n_i && $past(rst_n_i))
      else $error("internal reset released while rst_n_i was low");

endmodule

// ==== design/cfg_tap_decode.sv ====
//--------------------------------------
// Tap is a level; each field holds until
// its own address comes round again
//--------------------------------------
`timescale 1ns/1ps
`include "cfg_bridge_defines.svh"

module cfg_tap_decode
(
   input  logic                      AvlClk_i,
   input  logic                      rstn_reg,
   input  cfg_bridge_pkg::cfg_addr_t cfg_addr_i,
   input  cfg_bridge_pkg::cfg_data_t cfg_ctl_i,
   output cfg_bridge_pkg::busdev_t   bus_dev_o,
   output cfg_bridge_pkg::cfg_data_t dev_csr_o,
   output logic                      master_ena_o,
   output cfg_bridge_pkg::half_t     msi_ena_o,
   output cfg_bridge_pkg::half_t     msix_control_o,
   output cfg_bridge_pkg::half_t     msi_data_o,
   output cfg_bridge_pkg::msi_addr_t msi_addr_o
);

   cfg_bridge_pkg::cfg_addr_t cfg_addr_reg;
   cfg_bridge_pkg::cfg_data_t cfg_data_reg;

   cfg_bridge_pkg::busdev_t   busdev;
   cfg_bridge_pkg::cfg_data_t dev_csr;
   cfg_bridge_pkg::half_t     prmcsr;   // Command/status, bit 2 is master enable
   cfg_bridge_pkg::half_t     msi_ena;
   cfg_bridge_pkg::half_t     msix_control;
   cfg_bridge_pkg::half_t     msi_data;
   cfg_bridge_pkg::msi_addr_t msi_addr;

   // Pipeline stage for the tap bus
   always_ff @(posedge AvlClk_i or negedge rstn_reg)
   begin
      if (!rstn_reg)
      begin
         cfg_addr_reg <= '0;
         cfg_data_reg <= '0;
      end
      else
      begin
         cfg_addr_reg <= cfg_addr_i;
         cfg_data_reg <= cfg_ctl_i;
      end
   end

   // Address decode into the field registers
   always_ff @(posedge AvlClk_i or negedge rstn_reg)
   begin
      if (!rstn_reg)
      begin
         busdev       <= '0;
         dev_csr      <= '0;
         prmcsr       <= '0;
         msi_ena      <= '0;
         msix_control <= '0;
         msi_data     <= '0;
         msi_addr     <= '0;
      end
      else
      begin
         case (cfg_addr_reg)
            `CFG_ADR_DEVCSR:    dev_csr <= {16'h0, cfg_data_reg[31:16]};
            `CFG_ADR_PRMCSR:    prmcsr <= cfg_data_reg[23:8];
            `CFG_ADR_MSIADR_L0: msi_addr[11:0] <= cfg_data_reg[31:20];
            `CFG_ADR_MSIADR_L1: msi_addr[31:12] <= cfg_data_reg[31:12];
            `CFG_ADR_MSIADR_H0: msi_addr[43:32] <= cfg_data_reg[31:20];
            `CFG_ADR_MSIADR_H1: msi_addr[63:44] <= cfg_data_reg[31:12];
            `CFG_ADR_MSICTL:
            begin
               msi_ena      <= cfg_data_reg[15:0];
               msix_control <= cfg_data_reg[31:16];
            end
            `CFG_ADR_BUSDEV:
            begin
               busdev   <= cfg_data_reg[12:0];
               msi_data <= cfg_data_reg[31:16];
            end
            default:;   // Undecoded, hold everything
         endcase
      end
   end

   assign bus_dev_o      = busdev;
   assign dev_csr_o      = dev_csr;
   assign master_ena_o   = prmcsr[2];
   assign msi_ena_o      = msi_ena;
   assign msix_control_o = msix_control;
   assign msi_data_o     = msi_data;
   assign msi_addr_o     = msi_addr;

endmodule

// ==== design/msi_intf_reg.sv ====
//--------------------------------------
// Adds one cycle to MSI fields; bit 81 is
// the live master enable, one cycle ahead
//--------------------------------------
`timescale 1ns/1ps

module msi_intf_reg
(
   input  logic                       AvlClk_i,
   input  logic                       rstn_reg,
   input  cfg_bridge_pkg::half_t      msi_ena_i,
   input  cfg_bridge_pkg::half_t      msix_control_i,
   input  cfg_bridge_pkg::half_t      msi_data_i,
   input  cfg_bridge_pkg::msi_addr_t  msi_addr_i,
   input  logic                       master_ena_i,
   output cfg_bridge_pkg::msi_intfc_t msi_intfc_o,
   output cfg_bridge_pkg::half_t      msi_control_o,
   output cfg_bridge_pkg::half_t      msix_intfc_o
);

   cfg_bridge_pkg::half_t     msi_ena_reg;
   cfg_bridge_pkg::half_t     msix_control_reg;
   cfg_bridge_pkg::half_t     msi_data_reg;
   cfg_bridge_pkg::msi_addr_t msi_addr_reg;

   always_ff @(posedge AvlClk_i or negedge rstn_reg)
   begin
      if (!rstn_reg)
      begin
         msi_ena_reg      <= '0;
         msix_control_reg <= '0;
         msi_data_reg     <= '0;
         msi_addr_reg     <= '0;
      end
      else
      begin
         msi_ena_reg      <= msi_ena_i;
         msix_control_reg <= msix_control_i;
         msi_data_reg     <= msi_data_i;
         msi_addr_reg     <= msi_addr_i;
      end
   end

   // Status word packing
   assign msi_intfc_o.msi_addr   = msi_addr_reg;
   assign msi_intfc_o.msi_data   = msi_data_reg;
   assign msi_intfc_o.msi_ena    = msi_ena_reg[0];   // MSI enable bit of control
   assign msi_intfc_o.master_ena = master_ena_i;

   assign msi_control_o = msi_ena_reg;
   assign msix_intfc_o  = msix_control_reg;

endmodule

// ==== design/rxm_rdata_mux.sv ====
//--------------------------------------
// No latency; at most one enabled port may
// return read data in any cycle
//--------------------------------------
`timescale 1ns/1ps
`include "cfg_bridge_defines.svh"

module rxm_rdata_mux
#(
   parameter cfg_bridge_pkg::rxm_vec_t PORT_ENA = `RXM_PORT_ENA
)
(
   input  logic                                        AvlClk_i,
   input  logic                                        rstn_reg,
   input  cfg_bridge_pkg::rxm_vec_t                    rxm_rd_valid_i,
   input  cfg_bridge_pkg::rxm_data_t [`RXM_PORTS-1:0]  rxm_rd_data_i,
   input  cfg_bridge_pkg::rxm_vec_t                    rxm_wait_i,
   output cfg_bridge_pkg::rxm_vec_t                    rxm_wait_o,
   output logic                                        txs_rd_valid_o,
   output cfg_bridge_pkg::rxm_data_t                   txs_rd_data_o
);

   cfg_bridge_pkg::rxm_vec_t valid_gated;

   // Disabled BARs never return data and always stall
   assign valid_gated = rxm_rd_valid_i & PORT_ENA;
   assign rxm_wait_o  = rxm_wait_i | ~PORT_ENA;

   assign txs_rd_valid_o = |valid_gated;

   // AND-OR merge of the one-hot returns, zero when idle
   always_comb
   begin
      txs_rd_data_o = '0;
      for (int p = 0; p < `RXM_PORTS; p++)
      begin
         if (valid_gated[p])
         begin
            txs_rd_data_o = txs_rd_data_o | rxm_rd_data_i[p];
         end
      end
   end

   // The attached slaves must never overlap their read returns
   a_one_hot_return: assert property (@(posedge AvlClk_i) disable iff (!rstn_reg)
      $onehot0(valid_gated))
      else $error("more than one enabled port returned read data");

endmodule

// ==== design/pcie_app_cfg_top.sv ====
//--------------------------------------
// Config tap glue and read-return merge
//--------------------------------------
`timescale 1ns/1ps
`include "cfg_bridge_defines.svh"

module pcie_app_cfg_top
(
   input  logic                                        AvlClk_i,
   input  logic                                        rst_n_i,
   input  cfg_bridge_pkg::cfg_addr_t                   cfg_addr_i,
   input  cfg_bridge_pkg::cfg_data_t                   cfg_ctl_i,
   input  cfg_bridge_pkg::rxm_vec_t                    rxm_rd_valid_i,
   input  cfg_bridge_pkg::rxm_data_t [`RXM_PORTS-1:0]  rxm_rd_data_i,
   input  cfg_bridge_pkg::rxm_vec_t                    rxm_wait_i,
   output cfg_bridge_pkg::busdev_t                     bus_dev_o,
   output cfg_bridge_pkg::cfg_data_t                   dev_csr_o,
   output logic                                        master_ena_o,
   output cfg_bridge_pkg::msi_intfc_t                  msi_intfc_o,
   output cfg_bridge_pkg::half_t                       msi_control_o,
   output cfg_bridge_pkg::half_t                       msix_intfc_o,
   output cfg_bridge_pkg::rxm_vec_t                    rxm_wait_o,
   output logic                                        txs_rd_valid_o,
   output cfg_bridge_pkg::rxm_data_t                   txs_rd_data_o
);

   logic                      rstn_reg;
   logic                      master_ena;   // Also feeds bit 81 of the status word
   cfg_bridge_pkg::half_t     msi_ena;
   cfg_bridge_pkg::half_t     msix_control;
   cfg_bridge_pkg::half_t     msi_data;
   cfg_bridge_pkg::msi_addr_t msi_addr;

   reset_sync reset_sync_i
   (
      .AvlClk_i (AvlClk_i),
      .rst_n_i  (rst_n_i),
      .rstn_o   (rstn_reg)
   );

   cfg_tap_decode cfg_tap_decode_i
   (
      .AvlClk_i       (AvlClk_i),
      .rstn_reg       (rstn_reg),
      .cfg_addr_i     (cfg_addr_i),
      .cfg_ctl_i      (cfg_ctl_i),
      .bus_dev_o      (bus_dev_o),
      .dev_csr_o      (dev_csr_o),
      .master_ena_o   (master_ena),
      .msi_ena_o      (msi_ena),
      .msix_control_o (msix_control),
      .msi_data_o     (msi_data),
      .msi_addr_o     (msi_addr)
   );

   assign master_ena_o = master_ena;

   msi_intf_reg msi_intf_reg_i
   (
      .AvlClk_i       (AvlClk_i),
      .rstn_reg       (rstn_reg),
      .msi_ena_i      (msi_ena),
      .msix_control_i (msix_control),
      .msi_data_i     (msi_data),
      .msi_addr_i     (msi_addr),
      .master_ena_i   (master_ena),
      .msi_intfc_o    (msi_intfc_o),
      .msi_control_o  (msi_control_o),
      .msix_intfc_o   (msix_intfc_o)
   );

   rxm_rdata_mux #(.PORT_ENA(`RXM_PORT_ENA)) rxm_rdata_mux_i
   (
      .AvlClk_i       (AvlClk_i),
      .rstn_reg       (rstn_reg),
      .rxm_rd_valid_i (rxm_rd_valid_i),
      .rxm_rd_data_i  (rxm_rd_data_i),
      .rxm_wait_i     (rxm_wait_i),
      .rxm_wait_o     (rxm_wait_o),
      .txs_rd_valid_o (txs_rd_valid_o),
      .txs_rd_data_o  (txs_rd_data_o)
   );

endmodule

// ==== sim/tb_pcie_app_cfg.sv ====
//--------------------------------------
// Random run from seed 27; every output is
// compared with the model at the falling edge
//--------------------------------------
`timescale 1ns/1ps
`include "cfg_bridge_defines.svh"

module tb_pcie_app_cfg;

   localparam cfg_bridge_pkg::rxm_vec_t PORT_ENA = `RXM_PORT_ENA;
   localparam int NUM_CYCLES    = 2000;
   localparam int RESET_TIMEOUT = 20;

   logic                                       AvlClk_i;
   logic                                       rst_n_i;
   cfg_bridge_pkg::cfg_addr_t                  cfg_addr_i;
   cfg_bridge_pkg::cfg_data_t                  cfg_ctl_i;
   cfg_bridge_pkg::rxm_vec_t                   rxm_rd_valid_i;
   cfg_bridge_pkg::rxm_data_t [`RXM_PORTS-1:0] rxm_rd_data_i;
   cfg_bridge_pkg::rxm_vec_t                   rxm_wait_i;
   cfg_bridge_pkg::busdev_t                    bus_dev_o;
   cfg_bridge_pkg::cfg_data_t                  dev_csr_o;
   logic                                       master_ena_o;
   cfg_bridge_pkg::msi_intfc_t                 msi_intfc_o;
   cfg_bridge_pkg::half_t                      msi_control_o;
   cfg_bridge_pkg::half_t                      msix_intfc_o;
   cfg_bridge_pkg::rxm_vec_t                   rxm_wait_o;
   logic                                       txs_rd_valid_o;
   cfg_bridge_pkg::rxm_data_t                  txs_rd_data_o;

   logic [31:0] rng_state;
   int          error_count;
   logic        checking;

   // Model state for reset release, tap stage, fields and MSI outputs
   logic [1:0]                m_rst_cnt;
   cfg_bridge_pkg::cfg_addr_t m_pipe_addr;
   cfg_bridge_pkg::cfg_data_t m_pipe_data;
   cfg_bridge_pkg::busdev_t   m_busdev;
   cfg_bridge_pkg::cfg_data_t m_dev_csr;
   cfg_bridge_pkg::half_t     m_prmcsr;
   cfg_bridge_pkg::half_t     m_msi_ena;
   cfg_bridge_pkg::half_t     m_msix_ctl;
   cfg_bridge_pkg::half_t     m_msi_data;
   cfg_bridge_pkg::msi_addr_t m_msi_addr;
   cfg_bridge_pkg::half_t     d_msi_ena;
   cfg_bridge_pkg::half_t     d_msix_ctl;
   cfg_bridge_pkg::half_t     d_msi_data;
   cfg_bridge_pkg::msi_addr_t d_msi_addr;

   pcie_app_cfg_top pcie_app_cfg_top_i
   (
      .AvlClk_i       (AvlClk_i),
      .rst_n_i        (rst_n_i),
      .cfg_addr_i     (cfg_addr_i),
      .cfg_ctl_i      (cfg_ctl_i),
      .rxm_rd_valid_i (rxm_rd_valid_i),
      .rxm_rd_data_i  (rxm_rd_data_i),
      .rxm_wait_i     (rxm_wait_i),
      .bus_dev_o      (bus_dev_o),
      .dev_csr_o      (dev_csr_o),
      .master_ena_o   (master_ena_o),
      .msi_intfc_o    (msi_intfc_o),
      .msi_control_o  (msi_control_o),
      .msix_intfc_o   (msix_intfc_o),
      .rxm_wait_o     (rxm_wait_o),
      .txs_rd_valid_o (txs_rd_valid_o),
      .txs_rd_data_o  (txs_rd_data_o)
   );

   initial
   begin
      AvlClk_i = 1'b0;
      forever #4 AvlClk_i = ~AvlClk_i;
   end

   // 32-bit xorshift
   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic report_mismatch(input string name, input string exp_s, input string act_s);
      error_count++;
      $display("** Error: %s expected %s actual %s", name, exp_s, act_s);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", name);
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_busdev(input string name, input cfg_bridge_pkg::busdev_t exp,
                               input cfg_bridge_pkg::busdev_t act);
      if (act !== exp)
         report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_csr(input string name, input cfg_bridge_pkg::cfg_data_t exp,
                            input cfg_bridge_pkg::cfg_data_t act);
      if (act !== exp)
         report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_half(input string name, input cfg_bridge_pkg::half_t exp,
                             input cfg_bridge_pkg::half_t act);
      if (act !== exp)
         report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_status(input string name, input cfg_bridge_pkg::msi_intfc_t exp,
                               input cfg_bridge_pkg::msi_intfc_t act);
      if (act !== exp)
         report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_rdata(input string name, input cfg_bridge_pkg::rxm_data_t exp,
                              input cfg_bridge_pkg::rxm_data_t act);
      if (act !== exp)
         report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_vec(input string name, input cfg_bridge_pkg::rxm_vec_t exp,
                            input cfg_bridge_pkg::rxm_vec_t act);
      if (act !== exp)
         report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic drive_random();
      logic [31:0] r;
      r = next_rand();
      cfg_addr_i = r[`CFG_ADDR_W-1:0];   // Undecoded addresses too
      cfg_ctl_i  = next_rand();
      r = next_rand();
      rxm_wait_i = r[`RXM_PORTS-1:0];
      // No valid at all or one port that may be disabled
      if (r[10:8] < 3'd6)
         rxm_rd_valid_i = cfg_bridge_pkg::rxm_vec_t'(1) << r[10:8];
      else
         rxm_rd_valid_i = '0;
      for (int p = 0; p < `RXM_PORTS; p++)
         rxm_rd_data_i[p] = {next_rand(), next_rand()};
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (pcie_app_cfg_top_i.rstn_reg !== 1'b1)
      begin
         @(posedge AvlClk_i);
         #1;
         cycles++;
         if (cycles > RESET_TIMEOUT)
         begin
            error_count++;
            $display("Timeout: internal reset still low %0d cycles after release", cycles);
            $display("TEST FAIL");
            $fatal(1, "reset release timeout");
         end
      end
   endtask

   // Fields update one edge after the tap stage, MSI outputs one edge later
   always @(posedge AvlClk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         m_rst_cnt   <= '0;
         m_pipe_addr <= '0;
         m_pipe_data <= '0;
         m_busdev    <= '0;
         m_dev_csr   <= '0;
         m_prmcsr    <= '0;
         m_msi_ena   <= '0;
         m_msix_ctl  <= '0;
         m_msi_data  <= '0;
         m_msi_addr  <= '0;
         d_msi_ena   <= '0;
         d_msix_ctl  <= '0;
         d_msi_data  <= '0;
         d_msi_addr  <= '0;
      end
      else if (m_rst_cnt != 2'd2)
         m_rst_cnt <= m_rst_cnt + 2'd1;   // Internal reset still low on this edge
      else
      begin
         m_pipe_addr <= cfg_addr_i;
         m_pipe_data <= cfg_ctl_i;
         d_msi_ena   <= m_msi_ena;
         d_msix_ctl  <= m_msix_ctl;
         d_msi_data  <= m_msi_data;
         d_msi_addr  <= m_msi_addr;
         case (m_pipe_addr)
            `CFG_ADR_DEVCSR:    m_dev_csr <= {16'h0, m_pipe_data[31:16]};
            `CFG_ADR_PRMCSR:    m_prmcsr <= m_pipe_data[23:8];
            `CFG_ADR_MSIADR_L0: m_msi_addr[11:0] <= m_pipe_data[31:20];
            `CFG_ADR_MSIADR_L1: m_msi_addr[31:12] <= m_pipe_data[31:12];
            `CFG_ADR_MSIADR_H0: m_msi_addr[43:32] <= m_pipe_data[31:20];
            `CFG_ADR_MSIADR_H1: m_msi_addr[63:44] <= m_pipe_data[31:12];
            `CFG_ADR_MSICTL:
            begin
               m_msi_ena  <= m_pipe_data[15:0];
               m_msix_ctl <= m_pipe_data[31:16];
            end
            `CFG_ADR_BUSDEV:
            begin
               m_busdev   <= m_pipe_data[12:0];
               m_msi_data <= m_pipe_data[31:16];
            end
            default:;
         endcase
      end
   end

   always @(negedge AvlClk_i)
   begin
      cfg_bridge_pkg::msi_intfc_t exp_status;
      cfg_bridge_pkg::rxm_data_t  exp_data;
      cfg_bridge_pkg::rxm_vec_t   exp_wait;
      logic                       exp_valid;
      if (checking)
      begin
         exp_status.master_ena = m_prmcsr[2];   // Live enable without the extra register
         exp_status.msi_ena    = d_msi_ena[0];
         exp_status.msi_data   = d_msi_data;
         exp_status.msi_addr   = d_msi_addr;
         exp_valid = 1'b0;
         exp_data  = '0;
         for (int p = 0; p < `RXM_PORTS; p++)
         begin
            // Enabled ports pass wait through, disabled ports always stall
            if (PORT_ENA[p])
               exp_wait[p] = rxm_wait_i[p];
            else
               exp_wait[p] = 1'b1;
            if (rxm_rd_valid_i[p] && PORT_ENA[p])
            begin
               exp_valid = 1'b1;
               exp_data  = rxm_rd_data_i[p];
            end
         end
         check_bit("rstn_reg", m_rst_cnt == 2'd2, pcie_app_cfg_top_i.rstn_reg);
         check_busdev("bus_dev_o", m_busdev, bus_dev_o);
         check_csr("dev_csr_o", m_dev_csr, dev_csr_o);
         check_bit("master_ena_o", m_prmcsr[2], master_ena_o);
         check_status("msi_intfc_o", exp_status, msi_intfc_o);
         check_half("msi_control_o", d_msi_ena, msi_control_o);
         check_half("msix_intfc_o", d_msix_ctl, msix_intfc_o);
         check_vec("rxm_wait_o", exp_wait, rxm_wait_o);
         check_bit("txs_rd_valid_o", exp_valid, txs_rd_valid_o);
         check_rdata("txs_rd_data_o", exp_data, txs_rd_data_o);
      end
   end

   initial
   begin
      rng_state      = 32'd27;
      error_count    = 0;
      checking       = 1'b0;
      rst_n_i        = 1'b0;
      cfg_addr_i     = '0;
      cfg_ctl_i      = '0;
      rxm_rd_valid_i = '0;
      rxm_rd_data_i  = '0;
      rxm_wait_i     = '0;
      repeat (4) @(posedge AvlClk_i);
      #1;
      checking = 1'b1;
      rst_n_i  = 1'b1;
      wait_reset_release();
      for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
      begin
         @(posedge AvlClk_i);
         #1;
         drive_random();
         if (cyc == 1000)
            rst_n_i = 1'b0;   // Mid-run reset pulse
         else if (cyc == 1004)
            rst_n_i = 1'b1;
      end
      @(posedge AvlClk_i);
      if (error_count == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+include
design/cfg_bridge_pkg.sv
design/reset_sync.sv
design/cfg_tap_decode.sv
design/msi_intf_reg.sv
design/rxm_rdata_mux.sv
design/pcie_app_cfg_top.sv
sim/tb_pcie_app_cfg.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run with Verilator; the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_pcie_app_cfg -f build.f --Mdir obj_dir -o tb_pcie_app_cfg

./obj_dir/tb_pcie_app_cfg > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
